//--- hw/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// address windows, matched as (addr & mask) == base
`define RAM_BASE  32'h8000_0000
`define RAM_MASK  32'hFFFF_0000
`define SRAM_BASE 32'h0F00_0000
`define SRAM_MASK 32'hFFFF_0000

`define RAM_WORDS  1024
`define SRAM_WORDS 256   // smaller than its window, so the upper part aliases

`define SRAM_WAIT 3      // address-channel wait states of the slow sram

`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10
`define RESP_DECERR 2'b11

`endif

//--- hw/lsu_pkg.sv
package lsu_pkg;

  // encoded to match the AXI size field directly
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } access_size_t;

  typedef struct packed {
    logic         load;
    logic         store;
    access_size_t size;
    logic         sext;   // sign extend a byte or half load
    logic [31:0]  addr;
    logic [31:0]  data;   // store data, right aligned
  } lsu_req_t;

  typedef struct packed {
    logic        fault;
    logic [31:0] data;    // extended load data, zero for stores
  } lsu_resp_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  size;
  } axi_ar_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  size;
  } axi_aw_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
  } axi_w_t;

  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] resp;
  } axi_b_t;

endpackage

//--- hw/axi_sram.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module axi_sram #(
  parameter int depth_words = 1024,
  parameter int wait_cycles = 0
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             ar_valid,
  input  lsu_pkg::axi_ar_t ar,
  output logic             ar_ready,
  input  logic             aw_valid,
  input  lsu_pkg::axi_aw_t aw,
  output logic             aw_ready,
  input  logic             w_valid,
  input  lsu_pkg::axi_w_t  w,
  output logic             w_ready,
  output logic             r_valid,
  output lsu_pkg::axi_r_t  r,
  input  logic             r_ready,
  output logic             b_valid,
  output lsu_pkg::axi_b_t  b,
  input  logic             b_ready
);

  localparam int idx_w = $clog2(depth_words);
  localparam int cnt_w = $clog2(wait_cycles + 2);

  logic [31:0]      mem [depth_words];
  logic [cnt_w-1:0] wait_cnt;
  logic             waited, pending, idle;
  logic [idx_w-1:0] rd_idx, wr_idx;
  logic [31:0]      r_data_q;
  logic [1:0]       r_resp_q, b_resp_q;
  logic             wr_misaligned;

  // misaligned accesses are refused with SLVERR
  function automatic logic misaligned(input logic [31:0] addr, input logic [2:0] size);
    case (size)
      3'd0:    return 1'b0;
      3'd1:    return addr[0];
      3'd2:    return addr[1:0] != 2'b00;
      default: return 1'b1;
    endcase
  endfunction

  assign rd_idx  = ar.addr[idx_w+1:2];  // upper window bits alias onto the array
  assign wr_idx  = aw.addr[idx_w+1:2];
  assign idle    = ~r_valid & ~b_valid;
  assign pending = idle & (ar_valid | (aw_valid & w_valid));
  assign waited  = wait_cnt == cnt_w'(wait_cycles);

  assign ar_ready = ar_valid & idle & waited;
  assign aw_ready = aw_valid & w_valid & ~ar_valid & idle & waited;
  assign w_ready  = aw_ready;
  assign r        = '{data: r_data_q, resp: r_resp_q};
  assign b        = '{resp: b_resp_q};

  assign wr_misaligned = misaligned(aw.addr, aw.size);

  always_ff @(posedge clock) begin
    if (reset) begin
      wait_cnt <= '0;
      r_valid  <= 1'b0;
      b_valid  <= 1'b0;
    end else begin
      wait_cnt <= (pending && !waited) ? wait_cnt + 1'b1 : '0;
      if (ar_ready) begin
        r_valid <= 1'b1;
      end else if (r_ready) begin
        r_valid <= 1'b0;
      end
      if (aw_ready) begin
        b_valid <= 1'b1;
      end else if (b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (ar_ready) begin
      r_data_q <= mem[rd_idx];
      r_resp_q <= misaligned(ar.addr, ar.size) ? `RESP_SLVERR : `RESP_OKAY;
    end
    if (aw_ready) begin
      b_resp_q <= wr_misaligned ? `RESP_SLVERR : `RESP_OKAY;
      for (int i = 0; i < 4; i++) begin
        if (w.strb[i] && !wr_misaligned) begin
          mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
        end
      end
    end
  end

endmodule

//--- hw/axi_xbar.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module axi_xbar (
  input  logic             clock,
  input  logic             reset,
  input  logic             ar_valid,
  input  lsu_pkg::axi_ar_t ar,
  output logic             ar_ready,
  input  logic             aw_valid,
  input  lsu_pkg::axi_aw_t aw,
  output logic             aw_ready,
  input  logic             w_valid,
  input  lsu_pkg::axi_w_t  w,
  output logic             w_ready,
  output logic             r_valid,
  output lsu_pkg::axi_r_t  r,
  input  logic             r_ready,
  output logic             b_valid,
  output lsu_pkg::axi_b_t  b,
  input  logic             b_ready,
  output logic             ram_ar_valid, ram_aw_valid, ram_w_valid, ram_r_ready, ram_b_ready,
  output lsu_pkg::axi_ar_t ram_ar,
  output lsu_pkg::axi_aw_t ram_aw,
  output lsu_pkg::axi_w_t  ram_w,
  input  logic             ram_ar_ready, ram_aw_ready, ram_w_ready, ram_r_valid, ram_b_valid,
  input  lsu_pkg::axi_r_t  ram_r,
  input  lsu_pkg::axi_b_t  ram_b,
  output logic             sram_ar_valid, sram_aw_valid, sram_w_valid, sram_r_ready, sram_b_ready,
  output lsu_pkg::axi_ar_t sram_ar,
  output lsu_pkg::axi_aw_t sram_aw,
  output lsu_pkg::axi_w_t  sram_w,
  input  logic             sram_ar_ready, sram_aw_ready, sram_w_ready, sram_r_valid, sram_b_valid,
  input  lsu_pkg::axi_r_t  sram_r,
  input  lsu_pkg::axi_b_t  sram_b
);

  localparam logic [1:0] TGT_RAM  = 2'd0;
  localparam logic [1:0] TGT_SRAM = 2'd1;
  localparam logic [1:0] TGT_ERR  = 2'd2;

  logic [1:0] ar_tgt, wr_tgt;
  logic [1:0] rd_tgt_q, wr_tgt_q;
  logic       err_r_valid, err_b_valid;
  logic       err_ar_ready, err_wr_ready;

  function automatic logic [1:0] decode(input logic [31:0] addr);
    if ((addr & `RAM_MASK) == `RAM_BASE) begin
      return TGT_RAM;
    end else if ((addr & `SRAM_MASK) == `SRAM_BASE) begin
      return TGT_SRAM;
    end
    return TGT_ERR;
  endfunction

  assign ar_tgt = decode(ar.addr);
  assign wr_tgt = decode(aw.addr);  // w always travels with its aw

  assign ram_ar  = ar;
  assign ram_aw  = aw;
  assign ram_w   = w;
  assign sram_ar = ar;
  assign sram_aw = aw;
  assign sram_w  = w;

  assign ram_ar_valid  = ar_valid & (ar_tgt == TGT_RAM);
  assign sram_ar_valid = ar_valid & (ar_tgt == TGT_SRAM);
  assign ram_aw_valid  = aw_valid & (wr_tgt == TGT_RAM);
  assign sram_aw_valid = aw_valid & (wr_tgt == TGT_SRAM);
  assign ram_w_valid   = w_valid & (wr_tgt == TGT_RAM);
  assign sram_w_valid  = w_valid & (wr_tgt == TGT_SRAM);
  assign ram_r_ready   = r_ready & (rd_tgt_q == TGT_RAM);
  assign sram_r_ready  = r_ready & (rd_tgt_q == TGT_SRAM);
  assign ram_b_ready   = b_ready & (wr_tgt_q == TGT_RAM);
  assign sram_b_ready  = b_ready & (wr_tgt_q == TGT_SRAM);

  // decode-error responder takes the address at once and answers next cycle
  assign err_ar_ready = ar_valid & ~err_r_valid;
  assign err_wr_ready = aw_valid & w_valid & ~err_b_valid;

  always_comb begin
    case (ar_tgt)
      TGT_RAM:  ar_ready = ram_ar_ready;
      TGT_SRAM: ar_ready = sram_ar_ready;
      default:  ar_ready = err_ar_ready;
    endcase
    case (wr_tgt)
      TGT_RAM:  {aw_ready, w_ready} = {ram_aw_ready, ram_w_ready};
      TGT_SRAM: {aw_ready, w_ready} = {sram_aw_ready, sram_w_ready};
      default:  {aw_ready, w_ready} = {2{err_wr_ready}};
    endcase
    case (rd_tgt_q)
      TGT_RAM:  {r_valid, r} = {ram_r_valid, ram_r};
      TGT_SRAM: {r_valid, r} = {sram_r_valid, sram_r};
      default:  {r_valid, r} = {err_r_valid, 32'd0, `RESP_DECERR};
    endcase
    case (wr_tgt_q)
      TGT_RAM:  {b_valid, b} = {ram_b_valid, ram_b};
      TGT_SRAM: {b_valid, b} = {sram_b_valid, sram_b};
      default:  {b_valid, b} = {err_b_valid, `RESP_DECERR};
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_tgt_q    <= TGT_ERR;
      wr_tgt_q    <= TGT_ERR;
      err_r_valid <= 1'b0;
      err_b_valid <= 1'b0;
    end else begin
      if (ar_valid && ar_ready) begin
        rd_tgt_q    <= ar_tgt;
        err_r_valid <= ar_tgt == TGT_ERR;
      end else if (r_ready) begin
        err_r_valid <= 1'b0;
      end
      if (aw_valid && aw_ready) begin
        wr_tgt_q    <= wr_tgt;
        err_b_valid <= wr_tgt == TGT_ERR;
      end else if (b_ready) begin
        err_b_valid <= 1'b0;
      end
    end
  end

endmodule

//--- hw/lsu.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu (
  input  logic               clock,
  input  logic               reset,
  input  lsu_pkg::lsu_req_t  req,
  input  logic [31:0]        exu_result,
  output logic               busy,
  output logic               resp_valid,
  output lsu_pkg::lsu_resp_t resp,
  output logic [31:0]        result,
  output logic               ar_valid,
  output lsu_pkg::axi_ar_t   ar,
  input  logic               ar_ready,
  output logic               aw_valid,
  output lsu_pkg::axi_aw_t   aw,
  input  logic               aw_ready,
  output logic               w_valid,
  output lsu_pkg::axi_w_t    w,
  input  logic               w_ready,
  input  logic               r_valid,
  input  lsu_pkg::axi_r_t    r,
  output logic               r_ready,
  input  logic               b_valid,
  input  lsu_pkg::axi_b_t    b,
  output logic               b_ready
);

  logic [31:0]           addr_q;
  lsu_pkg::access_size_t size_q;
  logic                  sext_q;
  logic [31:0]           data_q;
  logic                  take;
  logic [4:0]            lane_shift;
  logic [2:0]            axi_size;
  logic [3:0]            strb_base;
  logic [31:0]           rdata_shift;
  logic [31:0]           load_data;
  logic                  r_done;
  logic                  b_done;

  assign take   = ~busy & (req.load | req.store);
  assign r_done = r_ready & r_valid;
  assign b_done = b_ready & b_valid;

  assign lane_shift = {addr_q[1:0], 3'b000};
  assign axi_size   = {1'b0, size_q};

  always_comb begin
    case (size_q)
      lsu_pkg::SIZE_BYTE: strb_base = 4'b0001;
      lsu_pkg::SIZE_HALF: strb_base = 4'b0011;
      default:            strb_base = 4'b1111;
    endcase
  end

  assign ar = '{addr: addr_q, size: axi_size};
  assign aw = '{addr: addr_q, size: axi_size};
  assign w  = '{data: data_q << lane_shift, strb: strb_base << addr_q[1:0]};

  // bring the addressed lane down to bit 0 before extending
  assign rdata_shift = r.data >> lane_shift;

  always_comb begin
    case (size_q)
      lsu_pkg::SIZE_BYTE:
        load_data = {{24{sext_q & rdata_shift[7]}}, rdata_shift[7:0]};
      lsu_pkg::SIZE_HALF:
        load_data = {{16{sext_q & rdata_shift[15]}}, rdata_shift[15:0]};
      default:
        load_data = rdata_shift;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy       <= 1'b0;
      resp_valid <= 1'b0;
      ar_valid   <= 1'b0;
      aw_valid   <= 1'b0;
      w_valid    <= 1'b0;
      r_ready    <= 1'b0;
      b_ready    <= 1'b0;
    end else begin
      resp_valid <= 1'b0;
      if (!busy) begin
        busy     <= take;
        ar_valid <= req.load;
        aw_valid <= req.store & ~req.load;  // a load wins if both are set
        w_valid  <= req.store & ~req.load;
      end else begin
        if (ar_valid && ar_ready) begin
          ar_valid <= 1'b0;
          r_ready  <= 1'b1;
        end
        if (aw_valid && aw_ready) begin
          aw_valid <= 1'b0;
        end
        if (w_valid && w_ready) begin
          w_valid <= 1'b0;
          b_ready <= 1'b1;
        end
        if (r_done || b_done) begin
          r_ready    <= 1'b0;
          b_ready    <= 1'b0;
          busy       <= 1'b0;
          resp_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      addr_q <= req.addr;
      size_q <= req.size;
      sext_q <= req.sext;
      data_q <= req.data;
    end
    if (!busy) begin
      result <= exu_result;  // pass-through of the execute result while idle
    end else if (r_done) begin
      result <= load_data;
    end
    if (r_done) begin
      resp <= '{fault: r.resp != `RESP_OKAY, data: load_data};
    end else if (b_done) begin
      resp <= '{fault: b.resp != `RESP_OKAY, data: 32'd0};
    end
  end

endmodule

//--- hw/lsu_subsys_top.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_subsys_top (
  input  logic               clock,
  input  logic               reset,
  input  lsu_pkg::lsu_req_t  req,
  input  logic [31:0]        exu_result,
  output logic               busy,
  output logic               resp_valid,
  output lsu_pkg::lsu_resp_t resp,
  output logic [31:0]        result
);

  logic             ar_valid, aw_valid, w_valid, r_ready, b_ready;
  logic             ar_ready, aw_ready, w_ready, r_valid, b_valid;
  lsu_pkg::axi_ar_t ar, ram_ar, sram_ar;
  lsu_pkg::axi_aw_t aw, ram_aw, sram_aw;
  lsu_pkg::axi_w_t  w, ram_w, sram_w;
  lsu_pkg::axi_r_t  r, ram_r, sram_r;
  lsu_pkg::axi_b_t  b, ram_b, sram_b;
  logic             ram_ar_valid, ram_aw_valid, ram_w_valid, ram_r_ready, ram_b_ready;
  logic             ram_ar_ready, ram_aw_ready, ram_w_ready, ram_r_valid, ram_b_valid;
  logic             sram_ar_valid, sram_aw_valid, sram_w_valid, sram_r_ready, sram_b_ready;
  logic             sram_ar_ready, sram_aw_ready, sram_w_ready, sram_r_valid, sram_b_valid;

  lsu u_lsu (.*);

  axi_xbar u_xbar (.*);

  // fast on-chip ram, no wait states
  axi_sram #(.depth_words(`RAM_WORDS), .wait_cycles(0)) ram (
    .clock(clock), .reset(reset),
    .ar_valid(ram_ar_valid), .ar(ram_ar), .ar_ready(ram_ar_ready),
    .aw_valid(ram_aw_valid), .aw(ram_aw), .aw_ready(ram_aw_ready),
    .w_valid(ram_w_valid), .w(ram_w), .w_ready(ram_w_ready),
    .r_valid(ram_r_valid), .r(ram_r), .r_ready(ram_r_ready),
    .b_valid(ram_b_valid), .b(ram_b), .b_ready(ram_b_ready)
  );

  axi_sram #(.depth_words(`SRAM_WORDS), .wait_cycles(`SRAM_WAIT)) sram (
    .clock(clock), .reset(reset),
    .ar_valid(sram_ar_valid), .ar(sram_ar), .ar_ready(sram_ar_ready),
    .aw_valid(sram_aw_valid), .aw(sram_aw), .aw_ready(sram_aw_ready),
    .w_valid(sram_w_valid), .w(sram_w), .w_ready(sram_w_ready),
    .r_valid(sram_r_valid), .r(sram_r), .r_ready(sram_r_ready),
    .b_valid(sram_b_valid), .b(sram_b), .b_ready(sram_b_ready)
  );

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 8
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(period_ns / 2) clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

//--- verif/lsu_tb.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_tb;

  localparam int period_ns      = 40;
  localparam int request_budget = 300;
  localparam int cycles_each    = 20;
  localparam logic [31:0] unmapped_base = 32'h2000_0000;  // outside both windows

  logic               clock;
  logic               reset;
  lsu_pkg::lsu_req_t  req = '0;
  logic [31:0]        exu_result = 32'h0BAD_5EED;
  logic               busy;
  logic               resp_valid;
  lsu_pkg::lsu_resp_t resp;
  logic [31:0]        result;

  logic [7:0]  model [logic [31:0]];  // byte image of every mapped store so far
  logic        exp_fault = 1'b0;
  logic [31:0] exp_data = 32'd0;
  logic [31:0] exu_prev = 32'd0;
  logic        busy_prev = 1'b0;
  logic        awaiting = 1'b0;  // a taken request still waits for its response
  int          seed;

  tb_clock #(.period_ns(period_ns), .reset_cycles(8)) clock_gen (
    .clock(clock),
    .reset(reset)
  );

  lsu_subsys_top dut (
    .clock(clock),
    .reset(reset),
    .req(req),
    .exu_result(exu_result),
    .busy(busy),
    .resp_valid(resp_valid),
    .resp(resp),
    .result(result)
  );

  // the execute result changes every cycle so the idle pass-through shows up
  always @(posedge clock) begin
    exu_result <= exu_result * 32'd1103515245 + 32'd12345;
    exu_prev   <= exu_result;
    busy_prev  <= busy;
    if (!busy && (req.load || req.store)) begin
      awaiting <= 1'b1;
    end else if (resp_valid) begin
      awaiting <= 1'b0;
    end
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  function automatic logic is_mapped(input logic [31:0] addr);
    return ((addr & `RAM_MASK) == `RAM_BASE) || ((addr & `SRAM_MASK) == `SRAM_BASE);
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[7:0], addr[15:8], addr[23:16], addr[31:24]} ^ 32'h3C96_A50F;
  endfunction

  function automatic logic [31:0] expected_load(input logic [31:0] addr,
                                                input lsu_pkg::access_size_t size,
                                                input logic sext);
    case (size)
      lsu_pkg::SIZE_BYTE:
        return {{24{sext & model[addr][7]}}, model[addr]};
      lsu_pkg::SIZE_HALF:
        return {{16{sext & model[addr + 32'd1][7]}}, model[addr + 32'd1], model[addr]};
      default:
        return {model[addr + 32'd3], model[addr + 32'd2], model[addr + 32'd1], model[addr]};
    endcase
  endfunction

  task automatic update_model(input logic [31:0] addr, input lsu_pkg::access_size_t size,
                              input logic [31:0] data);
    int nbytes;
    nbytes = (size == lsu_pkg::SIZE_BYTE) ? 1 : (size == lsu_pkg::SIZE_HALF) ? 2 : 4;
    for (int i = 0; i < nbytes; i++) begin
      model[addr + 32'(i)] = data[8*i +: 8];
    end
  endtask

  task automatic issue_access(input logic is_load, input lsu_pkg::access_size_t size,
                              input logic sext, input logic [31:0] addr,
                              input logic [31:0] data);
    lsu_pkg::lsu_req_t request;
    request = '{load: is_load, store: !is_load, size: size, sext: sext,
                addr: addr, data: data};
    while (busy) begin
      @(posedge clock);
    end
    @(posedge clock);
    req       <= request;
    exp_fault <= !is_mapped(addr);
    exp_data  <= (is_load && is_mapped(addr)) ? expected_load(addr, size, sext) : 32'd0;
    if (!is_load && is_mapped(addr)) begin
      update_model(addr, size, data);
    end
    @(posedge clock);  // the DUT takes the request on this edge
    req.load  <= 1'b0;
    req.store <= 1'b0;
    do begin
      @(posedge clock);
    end while (!resp_valid);
  endtask

  task automatic exercise_window(input logic [31:0] base);
    logic [31:0] addr;
    for (int i = 0; i < 16; i++) begin
      addr = base + 32'(4 * i);
      issue_access(1'b0, lsu_pkg::SIZE_WORD, 1'b0, addr, fill_word(addr));
    end
    for (int i = 0; i < 16; i++) begin
      issue_access(1'b1, lsu_pkg::SIZE_WORD, 1'b0, base + 32'(4 * i), 32'd0);
    end
    for (int off = 0; off < 4; off++) begin
      issue_access(1'b1, lsu_pkg::SIZE_BYTE, 1'b0, base + 32'(4 + off), 32'd0);
      issue_access(1'b1, lsu_pkg::SIZE_BYTE, 1'b1, base + 32'(4 + off), 32'd0);
    end
    for (int off = 0; off < 4; off += 2) begin
      issue_access(1'b1, lsu_pkg::SIZE_HALF, 1'b0, base + 32'(4 + off), 32'd0);
      issue_access(1'b1, lsu_pkg::SIZE_HALF, 1'b1, base + 32'(4 + off), 32'd0);
    end
    // the upper store data bits must never reach memory
    issue_access(1'b0, lsu_pkg::SIZE_BYTE, 1'b0, base + 32'd9, 32'h1234_56C7);
    issue_access(1'b0, lsu_pkg::SIZE_HALF, 1'b0, base + 32'd14, 32'hFFFF_8E31);
    issue_access(1'b1, lsu_pkg::SIZE_WORD, 1'b0, base + 32'd8, 32'd0);
    issue_access(1'b1, lsu_pkg::SIZE_WORD, 1'b0, base + 32'd12, 32'd0);
  endtask

  task automatic random_accesses(input int count);
    logic [31:0]           rnd;
    logic [31:0]           base;
    logic [1:0]            off;
    lsu_pkg::access_size_t size;
    repeat (count) begin
      rnd = $random(seed);
      case (rnd % 32'd3)
        0:       base = `RAM_BASE;
        1:       base = `SRAM_BASE;
        default: base = unmapped_base;
      endcase
      size = (rnd[3:2] == 2'd3) ? lsu_pkg::SIZE_WORD : lsu_pkg::access_size_t'(rnd[3:2]);
      off  = (size == lsu_pkg::SIZE_BYTE) ? rnd[5:4] :
             (size == lsu_pkg::SIZE_HALF) ? {rnd[5], 1'b0} : 2'b00;
      issue_access(rnd[10], size, rnd[11], base + {26'd0, rnd[9:6], off}, $random(seed));
    end
  endtask

  reset_idle: assert property (@(posedge clock) reset |=> !busy && !resp_valid)
    else abort_run($sformatf("ERROR %0t busy,resp_valid expected 0,0 got %b,%b",
                             $time, $sampled(busy), $sampled(resp_valid)));

  busy_on_take: assert property (@(posedge clock) disable iff (reset)
      !busy && (req.load || req.store) |=> busy)
    else abort_run($sformatf("ERROR %0t busy expected 1 got %b", $time, $sampled(busy)));

  resp_on_release: assert property (@(posedge clock) disable iff (reset)
      busy_prev && !busy |-> resp_valid)
    else abort_run($sformatf("ERROR %0t resp_valid expected 1 got %b",
                             $time, $sampled(resp_valid)));

  release_on_resp: assert property (@(posedge clock) disable iff (reset)
      resp_valid |-> busy_prev && !busy)
    else abort_run($sformatf("ERROR %0t busy expected 1->0 got %b->%b",
                             $time, $sampled(busy_prev), $sampled(busy)));

  one_response: assert property (@(posedge clock) disable iff (reset)
      resp_valid |-> awaiting)
    else abort_run($sformatf("ERROR %0t resp_valid expected 0 got 1", $time));

  idle_result: assert property (@(posedge clock) disable iff (reset)
      !busy |=> result == exu_prev)
    else abort_run($sformatf("ERROR %0t result expected %h got %h",
                             $time, $sampled(exu_prev), $sampled(result)));

  resp_fault: assert property (@(posedge clock) disable iff (reset)
      resp_valid |-> resp.fault == exp_fault)
    else abort_run($sformatf("ERROR %0t resp.fault expected %b got %b",
                             $time, $sampled(exp_fault), $sampled(resp.fault)));

  resp_data: assert property (@(posedge clock) disable iff (reset)
      resp_valid |-> resp.data == exp_data)
    else abort_run($sformatf("ERROR %0t resp.data expected %h got %h",
                             $time, $sampled(exp_data), $sampled(resp.data)));

  initial begin
    #(request_budget * cycles_each * period_ns);
    abort_run("the run timed out before the request sequence finished");
  end

  initial begin
    seed = 32'h1999;
    @(posedge clock);
    while (reset) begin
      @(posedge clock);
    end
    exercise_window(`RAM_BASE);
    exercise_window(`SRAM_BASE);
    issue_access(1'b0, lsu_pkg::SIZE_WORD, 1'b0, unmapped_base + 32'd8, 32'hDEAD_BEEF);
    issue_access(1'b1, lsu_pkg::SIZE_WORD, 1'b0, unmapped_base + 32'd8, 32'd0);
    issue_access(1'b1, lsu_pkg::SIZE_WORD, 1'b0, `RAM_BASE + 32'd8, 32'd0);
    issue_access(1'b1, lsu_pkg::SIZE_WORD, 1'b0, `SRAM_BASE + 32'd8, 32'd0);
    random_accesses(200);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- project.f
+incdir+hw
hw/lsu_pkg.sv
hw/axi_sram.sv
hw/axi_xbar.sv
hw/lsu.sv
hw/lsu_subsys_top.sv
verif/tb_clock.sv
verif/lsu_tb.sv

//--- Makefile
TOP = lsu_tb

.PHONY: compile run clean

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): project.f hw/*.sv hw/*.svh verif/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -f project.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
